// ==== rtl/procPkg.sv ====
package procPkg;

    localparam int WordWidth = 16;
    localparam int RegIdxWidth = 3;

    typedef logic [WordWidth-1:0] wordT;
    typedef logic [RegIdxWidth-1:0] regIdxT;

    localparam regIdxT PcIdx = 3'd7; // r7 is the program counter

    // III field of the instruction
    typedef enum logic [2:0] {
        opMv, opMvt, opAdd, opSub, opLd, opSt, opAnd, opCmp
    } opcodeT;

    // branch condition sits in the rX field
    typedef enum logic [2:0] {
        condNone, condEq, condNe, condCc, condCs, condPl, condMi, condRsvd
    } condT;

    typedef enum logic [2:0] {
        stepT0, stepT1, stepT2, stepT3, stepT4, stepT5
    } tStepT;

    // selR0..selPc line up with the register index
    typedef enum logic [3:0] {
        selR0, selR1, selR2, selR3, selR4, selR5, selR6, selPc,
        selG, selImmSext, selImmHigh, selDin
    } busSelT;

    typedef enum logic [1:0] {aluAdd, aluSub, aluAnd} aluOpT;

    typedef struct packed {
        opcodeT      opcode;
        logic        imm;  // M bit
        regIdxT      rX;
        logic [8:0]  data; // immediate, or rY in the low bits
    } instrT;

    typedef struct packed {
        logic c;
        logic z;
        logic n;
    } flagsT;

    typedef struct packed {
        busSelT busSel;
        logic   rXWrite;
        logic   aLoad;
        logic   gLoad;
        aluOpT  aluOp;
        logic   flagLoad;
        logic   irLoad;
        logic   addrLoad;
        logic   doutLoad;
        logic   writeMem;
        logic   pcIncr;
        logic   pcLoad;
    } ctrlT;

endpackage

// ==== rtl/aluFlags.sv ====
`timescale 1ns/10ps

module aluFlags (
    input  logic           Clock,
    input  logic           rstN,
    input  procPkg::wordT  busData,
    input  logic           aLoad,
    input  logic           gLoad,
    input  logic           flagLoad,
    input  procPkg::aluOpT aluOp,
    output procPkg::wordT  g,
    output procPkg::flagsT flags
);
    import procPkg::*;

    wordT a;      // first operand, latched from the bus
    wordT result;
    logic carry;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            a <= '0;
        else if (aLoad)
            a <= busData;
    end

    always_comb begin
        carry = 1'b0;
        case (aluOp)
            aluAdd:
                {carry, result} = {1'b0, a} + {1'b0, busData};
            aluSub: // A + ~B + 1
                {carry, result} = {1'b0, a} + {1'b0, ~busData} + 17'd1;
            default:
                result = a & busData; // carry stays 0
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            g <= '0;
        else if (gLoad)
            g <= result;
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagLoad) begin
            flags.c <= carry;
            flags.z <= (result == '0);
            flags.n <= result[WordWidth-1]; // sign bit
        end
    end

endmodule

// ==== rtl/registerFile.sv ====
`timescale 1ns/10ps

module registerFile #(
    parameter procPkg::wordT ResetPc = '0
) (
    input  logic            Clock,
    input  logic            rstN,
    input  procPkg::wordT   busData,
    input  procPkg::regIdxT writeIdx,
    input  logic            rXWrite,
    input  logic            pcIncr,
    input  logic            pcLoad,
    output procPkg::wordT   regs [0:6],
    output procPkg::wordT   pc
);
    import procPkg::*;

    logic pcWrite; // explicit load or mv into r7

    assign pcWrite = pcLoad || (rXWrite && writeIdx == PcIdx);

    // r0 to r6, r5 is a plain register here
    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 7; i++)
                regs[i] <= '0;
        end else if (rXWrite && writeIdx != PcIdx) begin
            regs[writeIdx] <= busData;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            pc <= ResetPc;
        else if (pcWrite)
            pc <= busData;   // load wins over increment
        else if (pcIncr)
            pc <= pc + 1'b1;
    end

    // fetch increment and any pc write come from different steps
    pcSingleSource: assert property (@(posedge Clock) disable iff (!rstN)
        !(pcIncr && pcWrite))
        else $error("pc increment and load in the same cycle");

endmodule

// ==== rtl/controlUnit.sv ====
`timescale 1ns/10ps

module controlUnit (
    input  logic           Clock,
    input  logic           rstN,
    input  logic           Run,
    input  procPkg::instrT ir,
    input  procPkg::flagsT flags,
    output procPkg::ctrlT  ctrl
);
    import procPkg::*;

    // no source on the bus, outside the defined selector range
    localparam busSelT BusIdle = busSelT'(4'hF);

    tStepT  step, stepNext;
    logic   done;       // last step of the instruction
    busSelT rXSel;      // bus selector for rX
    busSelT rYSel;      // bus selector for rY
    busSelT operandSel; // second operand, rY or immediate
    condT   cond;
    logic   taken;

    assign rXSel = busSelT'({1'b0, ir.rX});
    assign rYSel = busSelT'({1'b0, ir.data[2:0]});
    assign operandSel = ir.imm ? selImmSext : rYSel;
    assign cond = condT'(ir.rX);

    function automatic logic branchTaken(condT c, flagsT f);
        case (c)
            condNone: return 1'b1;
            condEq:   return f.z;
            condNe:   return !f.z;
            condCc:   return !f.c;
            condCs:   return f.c;
            condPl:   return !f.n;
            condMi:   return f.n;
            default:  return 1'b0; // reserved code, never taken
        endcase
    endfunction

    assign taken = branchTaken(cond, flags);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN)
            step <= stepT0;
        else
            step <= stepNext;
    end

    always_comb begin
        case (step)
            stepT0:  stepNext = Run ? stepT1 : stepT0; // hold while Run is low
            stepT1:  stepNext = stepT2;
            stepT2:  stepNext = stepT3;
            stepT3:  stepNext = done ? stepT0 : stepT4;
            stepT4:  stepNext = done ? stepT0 : stepT5;
            default: stepNext = stepT0;                // T5 always ends
        endcase
    end

    // one control word per step
    always_comb begin
        ctrl = '0;
        ctrl.busSel = BusIdle;
        ctrl.aluOp = aluAdd;
        done = 1'b0;
        case (step)
            stepT0: begin // fetch address from pc
                ctrl.busSel = selPc;
                ctrl.addrLoad = 1'b1;
                ctrl.pcIncr = Run;
            end
            stepT1: ;     // memory read latency
            stepT2: ctrl.irLoad = 1'b1;
            stepT3: begin
                case (ir.opcode)
                    opMv: begin
                        ctrl.busSel = ir.imm ? selImmSext : rYSel;
                        ctrl.rXWrite = 1'b1;
                        done = 1'b1;
                    end
                    opMvt: begin
                        if (ir.imm) begin // mvt
                            ctrl.busSel = selImmHigh;
                            ctrl.rXWrite = 1'b1;
                            done = 1'b1;
                        end else if (taken) begin
                            ctrl.busSel = selPc; // A gets the incremented pc
                            ctrl.aLoad = 1'b1;
                        end else begin
                            done = 1'b1;         // branch falls through
                        end
                    end
                    opAdd, opSub, opAnd, opCmp: begin
                        ctrl.busSel = rXSel;
                        ctrl.aLoad = 1'b1;
                    end
                    default: begin // ld and st send rY to ADDR
                        ctrl.busSel = rYSel;
                        ctrl.addrLoad = 1'b1;
                    end
                endcase
            end
            stepT4: begin
                case (ir.opcode)
                    opMvt: begin // taken branch, G = pc + offset
                        ctrl.busSel = selImmSext;
                        ctrl.gLoad = 1'b1;
                    end
                    opAdd, opSub, opAnd: begin
                        ctrl.busSel = operandSel;
                        ctrl.aluOp = (ir.opcode == opAdd) ? aluAdd :
                                     (ir.opcode == opSub) ? aluSub : aluAnd;
                        ctrl.gLoad = 1'b1;
                        ctrl.flagLoad = 1'b1;
                    end
                    opCmp: begin
                        ctrl.busSel = operandSel;
                        ctrl.aluOp = aluSub; // flags only, G untouched
                        ctrl.flagLoad = 1'b1;
                        done = 1'b1;
                    end
                    opSt: begin
                        ctrl.busSel = rXSel;
                        ctrl.doutLoad = 1'b1;
                        ctrl.writeMem = 1'b1;
                        done = 1'b1;
                    end
                    default: ; // ld waits for DIN
                endcase
            end
            stepT5: begin
                case (ir.opcode)
                    opMvt: begin
                        ctrl.busSel = selG;
                        ctrl.pcLoad = 1'b1;
                    end
                    opLd: begin
                        ctrl.busSel = selDin;
                        ctrl.rXWrite = 1'b1;
                    end
                    default: begin // add, sub, and write back
                        ctrl.busSel = selG;
                        ctrl.rXWrite = 1'b1;
                    end
                endcase
                done = 1'b1;
            end
            default: ;
        endcase
    end

    // a store strobe comes only from st in T4 and that step ends the instruction
    writeOnlyInStore: assert property (@(posedge Clock) disable iff (!rstN)
        ctrl.writeMem |-> (step == stepT4 && ir.opcode == opSt) ##1 (step == stepT0))
        else $error("writeMem outside st T4");

endmodule

// ==== rtl/dataPath.sv ====
`timescale 1ns/10ps

module dataPath #(
    parameter procPkg::wordT ResetPc = '0
) (
    input  logic           Clock,
    input  logic           rstN,
    input  procPkg::ctrlT  ctrl,
    input  procPkg::wordT  DIN,
    output procPkg::instrT ir,
    output procPkg::flagsT flags,
    output procPkg::wordT  DOUT,
    output procPkg::wordT  ADDR,
    output logic           W
);
    import procPkg::*;

    wordT   busData;
    wordT   regs [0:6];
    wordT   pc;
    wordT   g;
    regIdxT regSel;  // register picked by an r0..r6 selector
    logic   anyLoad; // something takes the bus this cycle

    assign regSel = regIdxT'(ctrl.busSel[2:0]);
    assign anyLoad = ctrl.rXWrite || ctrl.aLoad || ctrl.gLoad || ctrl.flagLoad
                   || ctrl.addrLoad || ctrl.doutLoad || ctrl.pcLoad;

    always_comb begin
        case (ctrl.busSel)
            selR0, selR1, selR2, selR3, selR4, selR5, selR6:
                busData = regs[regSel];
            selPc:      busData = pc;
            selG:       busData = g;
            selImmSext: busData = {{7{ir.data[8]}}, ir.data}; // 9-bit signed
            selImmHigh: busData = {ir.data[7:0], 8'h00};      // upper byte
            selDin:     busData = DIN;
            default:    busData = '0;                         // idle bus
        endcase
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            ir <= '0;
            ADDR <= '0;
            DOUT <= '0;
            W <= 1'b0;
        end else begin
            if (ctrl.irLoad)
                ir <= instrT'(DIN);
            if (ctrl.addrLoad)
                ADDR <= busData;
            if (ctrl.doutLoad)
                DOUT <= busData;
            W <= ctrl.writeMem; // one cycle behind the store step
        end
    end

    registerFile #(.ResetPc(ResetPc)) regFile (
        .Clock   (Clock),
        .rstN    (rstN),
        .busData (busData),
        .writeIdx(ir.rX),
        .rXWrite (ctrl.rXWrite),
        .pcIncr  (ctrl.pcIncr),
        .pcLoad  (ctrl.pcLoad),
        .regs    (regs),
        .pc      (pc)
    );

    aluFlags alu (
        .Clock   (Clock),
        .rstN    (rstN),
        .busData (busData),
        .aLoad   (ctrl.aLoad),
        .gLoad   (ctrl.gLoad),
        .flagLoad(ctrl.flagLoad),
        .aluOp   (ctrl.aluOp),
        .g       (g),
        .flags   (flags)
    );

    // a load never samples the idle bus
    busDefinedOnLoad: assert property (@(posedge Clock) disable iff (!rstN)
        anyLoad |-> ctrl.busSel inside {[selR0:selDin]})
        else $error("bus load from undefined source");

endmodule

// ==== rtl/simpleProc.sv ====
`timescale 1ns/10ps

module simpleProc #(
    parameter procPkg::wordT ResetPc = '0
) (
    input  logic          Clock,
    input  logic          rstN,
    input  logic          Run,  // low holds the machine in T0
    input  procPkg::wordT DIN,
    output procPkg::wordT DOUT,
    output procPkg::wordT ADDR,
    output logic          W
);
    import procPkg::*;

    ctrlT  ctrl;  // control word for this cycle
    instrT ir;    // decoded by the control unit
    flagsT flags; // c, z, n for branches

    controlUnit ctrlUnit (
        .Clock(Clock),
        .rstN (rstN),
        .Run  (Run),
        .ir   (ir),
        .flags(flags),
        .ctrl (ctrl)
    );

    dataPath #(.ResetPc(ResetPc)) dp (
        .Clock(Clock),
        .rstN (rstN),
        .ctrl (ctrl),
        .DIN  (DIN),
        .ir   (ir),
        .flags(flags),
        .DOUT (DOUT),
        .ADDR (ADDR),
        .W    (W)
    );

endmodule

// ==== sim/syncMemory.sv ====
`timescale 1ns/10ps

module syncMemory #(
    parameter int AddrWidth = 8
) (
    input  logic          Clock,
    input  logic          wrEn,   // W from the processor
    input  procPkg::wordT addr,
    input  procPkg::wordT wrData,
    output procPkg::wordT rdData
);
    import procPkg::*;

    localparam int Depth = 1 << AddrWidth;

    wordT                 mem [0:Depth-1]; // preloaded by the testbench
    logic [AddrWidth-1:0] index;

    // upper address bits are ignored, the image repeats
    assign index = addr[AddrWidth-1:0];

    // one registered port, read data shows up the cycle after the address
    always @(posedge Clock) begin
        if (wrEn)
            mem[index] <= wrData;
        rdData <= mem[index];    // old word on a same-cycle write
    end

endmodule

// ==== sim/procTb.sv ====
`timescale 1ns/10ps

module procTb;
    import procPkg::*;

    localparam wordT ResetPc = '0;
    localparam int MemAddrWidth = 8;
    localparam int MemDepth = 1 << MemAddrWidth;
    localparam int ResetCycles = 16;
    localparam int GapCount = 6;      // Run-low gaps per run
    localparam int GapMaxLen = 3;     // longest gap in cycles
    localparam int MarginCycles = 100;
    localparam int Seed = 39592;

    logic Clock;
    logic rstN;
    logic Run;
    wordT DIN;
    wordT DOUT;
    wordT ADDR;
    logic W;

    string expName [$]; // expected writes, in program order
    wordT  expAddr [$];
    wordT  expData [$];
    int    imageWords;  // memory words in the image
    int    expIdx;      // next expected write
    int    cycleCount;  // cycles since reset release
    int    timeoutLimit;
    int    seedInit;
    int    gapStart;    // first expected write of the branch tests

    simpleProc #(.ResetPc(ResetPc)) simpleProc_inst (
        .Clock(Clock),
        .rstN (rstN),
        .Run  (Run),
        .DIN  (DIN),
        .DOUT (DOUT),
        .ADDR (ADDR),
        .W    (W)
    );

    syncMemory #(.AddrWidth(MemAddrWidth)) memInst (
        .Clock (Clock),
        .wrEn  (W),
        .addr  (ADDR),
        .wrData(DOUT),
        .rdData(DIN)
    );

    always #10 Clock = ~Clock; // 20 ns period

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string testName, input wordT expected, input wordT actual);
        if (expected !== actual)
            stopOnFailure($sformatf("ERROR %s expected %04h actual %04h",
                                    testName, expected, actual));
    endtask

    // every word differs with its full address, stray fetches stand out
    task automatic fillMemory();
        for (int i = 0; i < MemDepth; i++)
            memInst.mem[i] = {8'(i) ^ 8'hC3, 8'(i)};
    endtask

    task automatic loadVectors();
        int          fd;
        int          n;
        byte         tagChar;
        string       line;
        string       tag;
        string       name;
        logic [31:0] a;
        logic [31:0] v;
        fd = $fopen("sim/procVectors.txt", "r");
        if (fd == 0)
            stopOnFailure("cannot open sim/procVectors.txt");
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            tagChar = (n > 1) ? line.getc(0) : 8'h00;
            if (tagChar == "M") begin          // memory image word
                n = $sscanf(line, "%s %h %h", tag, a, v);
                if (n != 3 || a >= MemDepth)
                    stopOnFailure($sformatf("bad memory line in vectors file: %s", line));
                memInst.mem[a[MemAddrWidth-1:0]] = v[15:0];
                imageWords++;
            end else if (tagChar == "E") begin // expected write
                n = $sscanf(line, "%s %s %h %h", tag, name, a, v);
                if (n != 4)
                    stopOnFailure($sformatf("bad expected line in vectors file: %s", line));
                expName.push_back(name);
                expAddr.push_back(a[15:0]);
                expData.push_back(v[15:0]);
            end
        end
        $fclose(fd);
        if (expName.size() == 0)
            stopOnFailure("vectors file holds no expected writes");
    endtask

    // index of the first compare and branch result
    function automatic int firstBranchWrite();
        foreach (expName[i]) begin
            if (expName[i].substr(0, 5) == "branch")
                return i;
        end
        return 0;
    endfunction

    // one store per W cycle, compared against the next entry
    task automatic compareWrite();
        if (expIdx >= expName.size())
            stopOnFailure("processor wrote memory after the last expected write");
        checkValue({expName[expIdx], " address"}, expAddr[expIdx], ADDR);
        checkValue({expName[expIdx], " data"}, expData[expIdx], DOUT);
        expIdx++;
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        Run = 1'b0;
        expIdx = 0;
        cycleCount = 0;
        imageWords = 0;
        seedInit = $urandom(Seed);
        fillMemory();
        loadVectors();
        gapStart = firstBranchWrite();
        timeoutLimit = 6 * imageWords + GapCount * GapMaxLen + MarginCycles;
        repeat (ResetCycles) @(posedge Clock);
        #1 rstN = 1'b1;
        checkValue("resetWrite", 16'h0000, {15'b0, W}); // no store strobe out of reset
        @(posedge Clock);
        #1 Run = 1'b1;
        @(posedge Clock);                                 // first T0 with Run high
        #1;
        checkValue("resetFetch", ResetPc, ADDR);
        wait (expIdx >= gapStart);
        // short Run-low gaps, each one starts in a fetch step and holds the machine
        for (int g = 0; g < GapCount; g++) begin
            repeat (2 + $urandom % 20) @(posedge Clock);
            #1;
            while (simpleProc_inst.ctrlUnit.step != stepT0) begin
                @(posedge Clock);
                #1;
            end
            Run = 1'b0;
            repeat (1 + $urandom % GapMaxLen) @(posedge Clock);
            #1 Run = 1'b1;
        end
    end

    // outputs are settled by the falling edge
    always @(negedge Clock) begin
        if (rstN) begin
            cycleCount++;
            if (W)
                compareWrite();
            if (expIdx == expName.size()) begin
                $display("Done: no errors");
                $finish;
            end else if (cycleCount > timeoutLimit) begin
                stopOnFailure($sformatf("timeout after %0d cycles with %0d of %0d writes seen",
                                        cycleCount, expIdx, expName.size()));
            end
        end
    end

endmodule

// ==== sim/procVectors.txt ====
# M lines give one memory word as address and value in hex
# E lines give one expected store as test name, address and data in hex
M 0000 1C60  mv r6,#0x60 store pointer
M 0001 11F5  mv r0,#-11
M 0002 A006  st r0,[r6]
M 0003 32A5  mvt r1,#0xA5
M 0004 0401  mv r2,r1
M 0005 5C01  add r6,#1
M 0006 A406  st r2,[r6]
M 0007 543C  add r2,#0x3C
M 0008 740C  sub r2,#0x0C
M 0009 6400  sub r2,r0
M 000A 4401  add r2,r1 with carry out
M 000B 5C01  add r6,#1
M 000C A406  st r2,[r6]
M 000D C400  and r2,r0
M 000E D5F0  and r2,#-16
M 000F 5C01  add r6,#1
M 0010 A406  st r2,[r6]
M 0011 1680  mv r3,#0x80 data pointer
M 0012 8803  ld r4,[r3]
M 0013 5601  add r3,#1
M 0014 8A03  ld r5,[r3]
M 0015 5C01  add r6,#1
M 0016 AA06  st r5,[r6]
M 0017 5C01  add r6,#1
M 0018 A806  st r4,[r6]
M 0019 5C01  add r6,#1 branch results go to 0x66
M 001A 1401  mv r2,#1
M 001B F681  cmp r3,#0x81 zero result
M 001C 2201  beq +1
M 001D 5480  add r2,#0x80 only on the fall-through path
M 001E A406  st r2,[r6]
M 001F 1402  mv r2,#2
M 0020 F681  cmp r3,#0x81
M 0021 2401  bne +1
M 0022 5480  add r2,#0x80
M 0023 A406  st r2,[r6]
M 0024 1403  mv r2,#3
M 0025 E805  cmp r4,r5 borrow
M 0026 2601  bcc +1
M 0027 5480  add r2,#0x80
M 0028 A406  st r2,[r6]
M 0029 1404  mv r2,#4
M 002A E805  cmp r4,r5
M 002B 2801  bcs +1
M 002C 5480  add r2,#0x80
M 002D A406  st r2,[r6]
M 002E 1405  mv r2,#5
M 002F EA04  cmp r5,r4 negative result
M 0030 2C01  bmi +1
M 0031 5480  add r2,#0x80
M 0032 A406  st r2,[r6]
M 0033 1406  mv r2,#6
M 0034 EA04  cmp r5,r4
M 0035 2A01  bpl +1
M 0036 5480  add r2,#0x80
M 0037 A406  st r2,[r6]
M 0038 1407  mv r2,#7
M 0039 2E01  reserved condition never taken
M 003A 5480  add r2,#0x80
M 003B A406  st r2,[r6]
M 003C 1408  mv r2,#8
M 003D 2001  b +1
M 003E 5480  add r2,#0x80
M 003F A406  st r2,[r6]
M 0040 21FF  b -1 branch to self
M 0080 1234  data word
M 0081 BEEF  data word
E movImm 0060 FFF5
E movReg 0061 A500
E addSub 0062 4A3B
E andOps 0063 4A30
E loadStore 0064 BEEF
E loadStore 0065 1234
E branchEq 0066 0001
E branchNe 0066 0082
E branchCc 0066 0003
E branchCs 0066 0084
E branchMi 0066 0005
E branchPl 0066 0086
E branchRsvd 0066 0087
E branchNone 0066 0008

// ==== vlog.f ====
rtl/procPkg.sv
rtl/aluFlags.sv
rtl/registerFile.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/simpleProc.sv
sim/syncMemory.sv
sim/procTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module procTb -Mdir obj_dir -o procSim
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

simOutput=$(./obj_dir/procSim)
runStatus=$?
printf '%s\n' "$simOutput"
if [ "$runStatus" -ne 0 ]; then
    echo "simulation exited with status $runStatus"
    exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx "Done: no errors"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
